//--- rvc_expander.f
+incdir+tb
source/rvc_pkg.sv
source/rvc_expand_q0.sv
source/rvc_expand_q1.sv
source/rvc_expand_q2.sv
source/rvc_expander.sv
tb/rvc_expander_sva.sv
tb/tb_rvc_expander.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_rvc_expander -f rvc_expander.f --Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_rvc_expander 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "^TEST PASS$" && exit 0 || { echo "TEST FAIL"; exit 1; }

//--- tb/rvc_ref_model.svh
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

function automatic logic [31:0] sext(input logic [31:0] v, input int msb);
    return $signed(v << (31 - msb)) >>> (31 - msb);
endfunction

function automatic logic [31:0] fmt_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] fmt_s(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic logic [31:0] fmt_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] fmt_b(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] fmt_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// Expected registered result for one fetch word
function automatic void expand_model(input logic [31:0] word, output logic [31:0] instr_out,
                                     output logic comp_out, output logic illegal_out);
    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  r_hi;
    logic [4:0]  r_lo;
    logic [31:0] imm;
    logic [31:0] ins;
    logic        bad;
    c    = word[15:0];
    rd   = c[11:7];
    rs2  = c[6:2];
    r_hi = 5'd8 + {2'b00, c[9:7]}; // x8..x15
    r_lo = 5'd8 + {2'b00, c[4:2]};
    imm  = sext({26'd0, c[12], c[6:2]}, 5);
    ins  = word;
    bad  = 1'b0;
    case ({c[1:0], c[15:13]})
        5'b00_000: begin // C.ADDI4SPN
            imm = {22'd0, c[10:7], c[12:11], c[5], c[6], 2'b00};
            ins = fmt_i(imm, REG_SP, 3'b000, r_lo, OP_OP_IMM);
            bad = (imm == 32'd0);
        end
        5'b00_010: begin
            imm = {25'd0, c[5], c[12:10], c[6], 2'b00};
            ins = fmt_i(imm, r_hi, 3'b010, r_lo, OP_LOAD);
        end
        5'b00_110: begin
            imm = {25'd0, c[5], c[12:10], c[6], 2'b00};
            ins = fmt_s(imm, r_lo, r_hi, 3'b010, OP_STORE);
        end
        5'b01_000: ins = fmt_i(imm, rd, 3'b000, rd, OP_OP_IMM);
        5'b01_010: ins = fmt_i(imm, REG_ZERO, 3'b000, rd, OP_OP_IMM);
        5'b01_011: begin
            bad = (rd == REG_ZERO) || (imm == 32'd0);
            if (rd == REG_SP) begin
                imm = sext({22'd0, c[12], c[4:3], c[5], c[2], c[6], 4'd0}, 9);
                ins = fmt_i(imm, REG_SP, 3'b000, REG_SP, OP_OP_IMM);
            end else begin
                ins = {imm[19:0], rd, OP_LUI};
            end
        end
        5'b01_100: begin
            bad = c[12] && (c[11:10] != 2'b10); // ANDI has a full 6-bit immediate
            case (c[11:10])
                2'b00: ins = fmt_r(7'b0000000, rs2, r_hi, 3'b101, r_hi, OP_OP_IMM);
                2'b01: ins = fmt_r(7'b0100000, rs2, r_hi, 3'b101, r_hi, OP_OP_IMM);
                2'b10: ins = fmt_i(imm, r_hi, 3'b111, r_hi, OP_OP_IMM);
                default: begin
                    case (c[6:5])
                        2'b00: ins = fmt_r(7'b0100000, r_lo, r_hi, 3'b000, r_hi, OP_OP);
                        2'b01: ins = fmt_r(7'b0000000, r_lo, r_hi, 3'b100, r_hi, OP_OP);
                        2'b10: ins = fmt_r(7'b0000000, r_lo, r_hi, 3'b110, r_hi, OP_OP);
                        default: ins = fmt_r(7'b0000000, r_lo, r_hi, 3'b111, r_hi, OP_OP);
                    endcase
                end
            endcase
        end
        5'b01_101: begin
            imm = sext({20'd0, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0}, 11);
            ins = fmt_j(imm, REG_ZERO);
        end
        5'b01_110, 5'b01_111: begin
            imm = sext({23'd0, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0}, 8);
            ins = fmt_b(imm, REG_ZERO, r_hi, {2'b00, c[13]});
        end
        5'b10_000: begin
            ins = fmt_r(7'b0000000, rs2, rd, 3'b001, rd, OP_OP_IMM);
            bad = c[12];
        end
        5'b10_010: begin
            imm = {24'd0, c[3:2], c[12], c[6:4], 2'b00};
            ins = fmt_i(imm, REG_SP, 3'b010, rd, OP_LOAD);
            bad = (rd == REG_ZERO);
        end
        5'b10_100: begin
            if (!c[12]) begin
                bad = (rd == REG_ZERO);
                ins = (rs2 == REG_ZERO) ? fmt_i(32'd0, rd, 3'b000, REG_ZERO, OP_JALR)
                                        : fmt_r(7'b0000000, rs2, REG_ZERO, 3'b000, rd, OP_OP);
            end else if (rs2 != REG_ZERO) begin
                ins = fmt_r(7'b0000000, rs2, rd, 3'b000, rd, OP_OP); // C.ADD
            end else if (rd != REG_ZERO) begin
                ins = fmt_i(32'd0, rd, 3'b000, REG_RA, OP_JALR); // C.JALR
            end else begin
                ins = fmt_i(32'd1, REG_ZERO, 3'b000, REG_ZERO, OP_SYSTEM); // EBREAK
            end
        end
        5'b10_110: begin
            imm = {24'd0, c[8:7], c[12:9], 2'b00};
            ins = fmt_s(imm, rs2, REG_SP, 3'b010, OP_STORE);
        end
        default: bad = (c[1:0] != 2'b11);
    endcase
    comp_out    = (c[1:0] != 2'b11);
    illegal_out = bad;
    instr_out   = bad ? word : ins;
endfunction

`endif

//--- tb/tb_rvc_expander.sv
`default_nettype none

module tb_rvc_expander;

    timeunit 1ns;
    timeprecision 1ps;

    import rvc_pkg::*;

    localparam int NUM_WORDS  = 5000;
    localparam int MAX_CYCLES = 20000;

    logic        clk;
    logic        rst_n;
    logic        valid;
    logic [31:0] instr;
    logic        dut_valid;
    logic [31:0] dut_instr;
    logic        dut_is_compressed;
    logic        dut_illegal;

    integer      seed;
    int          words;
    int          cycles;
    logic        exp_valid; // One-deep expected stage, data holds when idle
    logic [31:0] exp_instr;
    logic        exp_compressed;
    logic        exp_illegal;

    `include "rvc_ref_model.svh"

    rvc_expander uut (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_valid         (valid),
        .i_instr         (instr),
        .o_valid         (dut_valid),
        .o_instr         (dut_instr),
        .o_is_compressed (dut_is_compressed),
        .o_illegal       (dut_illegal)
    );

    bind rvc_expander rvc_expander_sva u_sva (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .i_instr         (i_instr),
        .o_valid         (o_valid),
        .o_instr         (o_instr),
        .o_is_compressed (o_is_compressed),
        .o_illegal       (o_illegal)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs();
        string tag;
        tag = $sformatf("word %0d", words);
        check_value({tag, " o_valid"}, {31'd0, exp_valid}, {31'd0, dut_valid});
        check_value({tag, " o_instr"}, exp_instr, dut_instr);
        check_value({tag, " o_is_compressed"}, {31'd0, exp_compressed}, {31'd0, dut_is_compressed});
        check_value({tag, " o_illegal"}, {31'd0, exp_illegal}, {31'd0, dut_illegal});
    endtask

    // Random fetch word, steered toward the zero-field corners
    task automatic random_word(output logic [31:0] word);
        logic [31:0] sel;
        word = $random(seed);
        sel  = $random(seed);
        if (sel[2:0] == 3'd0) begin
            word[1:0] = 2'b11;
        end else begin
            word[1:0] = 2'(sel[5:3] % 3'd3);
            case (sel[11:8])
                4'd0: word[11:7] = 5'd0;
                4'd1: word[6:2] = 5'd0;
                4'd2: word[11:2] = 10'd0;
                4'd3: word[12:5] = 8'd0;
                4'd4: {word[12], word[6:2]} = 6'd0;
                default: ;
            endcase
        end
    endtask

    task automatic apply_word();
        logic [31:0] word;
        logic [31:0] v;
        random_word(word);
        v     = $random(seed);
        valid = (v[3:0] < 4'd13);
        instr = word;
        if (valid) begin
            words++;
            expand_model(word, exp_instr, exp_compressed, exp_illegal);
        end
        exp_valid = valid;
    endtask

    task automatic wait_idle(input int max_cycles);
        int n;
        n = 0;
        while (dut_valid !== 1'b0) begin
            if (n == max_cycles) begin
                $display("Timeout: o_valid stayed high after the input went idle");
                $display("TEST FAIL");
                $fatal(1, "idle timeout");
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        valid          = 1'b0;
        instr          = '0;
        seed           = 32'hfc0d_5f00;
        words          = 0;
        cycles         = 0;
        exp_valid      = 1'b0;
        exp_instr      = '0;
        exp_compressed = 1'b0;
        exp_illegal    = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_outputs(); // Reset values
        rst_n = 1'b1;
        while (words < NUM_WORDS) begin
            if (cycles == MAX_CYCLES) begin
                $display("Timeout: fewer than %0d valid words were sent", NUM_WORDS);
                $display("TEST FAIL");
                $fatal(1, "stimulus timeout");
            end else begin
                @(negedge clk);
                check_outputs();
                apply_word();
                cycles++;
            end
        end
        @(negedge clk);
        check_outputs();
        valid     = 1'b0;
        exp_valid = 1'b0;
        wait_idle(4);
        check_outputs();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/rvc_expander_sva.sv
`default_nettype none

module rvc_expander_sva (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_valid,
    input logic [31:0] i_instr,
    input logic        o_valid,
    input logic [31:0] o_instr,
    input logic        o_is_compressed,
    input logic        o_illegal
);

    timeunit 1ns;
    timeprecision 1ps;

    illegal_is_compressed: assert property (@(posedge i_clk) o_illegal |-> o_is_compressed)
        else $error("o_illegal set on a word that is not compressed");

    idle_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_valid)
        else $error("o_valid high in the cycle after reset");

    // Full-width words pass straight through the register
    full_word_passes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_valid && i_instr[1:0] == 2'b11) |=> (o_instr == $past(i_instr)))
        else $error("Non-compressed word changed on its way through");

endmodule

`default_nettype wire

//--- source/rvc_expander.sv
`default_nettype none

module rvc_expander (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  logic [rvc_pkg::INSTR_W-1:0] i_instr,
    output logic                        o_valid,
    output logic [rvc_pkg::INSTR_W-1:0] o_instr,
    output logic                        o_is_compressed,
    output logic                        o_illegal
);

    import rvc_pkg::*;

    quadrant_e            quadrant;
    logic [INSTR_W-1:0]   q0_instr;
    logic [INSTR_W-1:0]   q1_instr;
    logic [INSTR_W-1:0]   q2_instr;
    logic                 q0_illegal;
    logic                 q1_illegal;
    logic                 q2_illegal;
    logic [INSTR_W-1:0]   next_instr;
    logic                 next_is_compressed;
    logic                 next_illegal;

    assign quadrant = quadrant_e'(i_instr[1:0]);

    rvc_expand_q0 u_expand_q0 (
        .i_cinstr  (i_instr[CINSTR_W-1:0]),
        .o_instr   (q0_instr),
        .o_illegal (q0_illegal)
    );

    rvc_expand_q1 u_expand_q1 (
        .i_cinstr  (i_instr[CINSTR_W-1:0]),
        .o_instr   (q1_instr),
        .o_illegal (q1_illegal)
    );

    rvc_expand_q2 u_expand_q2 (
        .i_cinstr  (i_instr[CINSTR_W-1:0]),
        .o_instr   (q2_instr),
        .o_illegal (q2_illegal)
    );

    always_comb begin
        next_instr         = i_instr; // Full-width words pass through
        next_is_compressed = 1'b1;
        next_illegal       = 1'b0;
        case (quadrant)
            Q0: begin
                next_instr   = q0_instr;
                next_illegal = q0_illegal;
            end
            Q1: begin
                next_instr   = q1_instr;
                next_illegal = q1_illegal;
            end
            Q2: begin
                next_instr   = q2_instr;
                next_illegal = q2_illegal;
            end
            default: begin
                next_is_compressed = 1'b0;
            end
        endcase
        if (next_illegal) begin
            next_instr = i_instr; // Raw word for the trap handler
        end
    end

    // One-cycle output stage, data holds while idle
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_instr         <= '0;
            o_is_compressed <= 1'b0;
            o_illegal       <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_instr         <= next_instr;
                o_is_compressed <= next_is_compressed;
                o_illegal       <= next_illegal;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rvc_expand_q2.sv
`default_nettype none

module rvc_expand_q2 (
    input  logic [rvc_pkg::CINSTR_W-1:0] i_cinstr,
    output logic [rvc_pkg::INSTR_W-1:0]  o_instr,
    output logic                         o_illegal
);

    import rvc_pkg::*;

    c_funct3_q2_e funct3;
    logic [4:0]   rd;
    logic [4:0]   rs2;
    logic [11:0]  lwsp_imm;
    logic [11:0]  swsp_imm;
    logic         rd_zero;
    logic         rs2_zero;

    assign funct3   = c_funct3_q2_e'(i_cinstr[15:13]);
    assign rd       = i_cinstr[11:7]; // Also rs1 in the JR family
    assign rs2      = i_cinstr[6:2];
    assign rd_zero  = (rd == REG_ZERO);
    assign rs2_zero = (rs2 == REG_ZERO);

    // uimm[5|4:2|7:6] scaled by 4
    assign lwsp_imm = {4'b0, i_cinstr[3:2], i_cinstr[12], i_cinstr[6:4], 2'b00};
    // uimm[5:2|7:6] scaled by 4
    assign swsp_imm = {4'b0, i_cinstr[8:7], i_cinstr[12:9], 2'b00};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (funct3)
            C_SLLI: begin
                o_instr   = {7'b0000000, rs2, rd, 3'b001, rd, OP_OP_IMM};
                o_illegal = i_cinstr[12];
            end
            C_LWSP: begin
                o_instr   = {lwsp_imm, REG_SP, 3'b010, rd, OP_LOAD};
                o_illegal = rd_zero;
            end
            C_JR_MV_ADD: begin
                if (!i_cinstr[12]) begin
                    o_illegal = rd_zero;
                    if (rs2_zero) begin // JR
                        o_instr = {12'b0, rd, 3'b000, REG_ZERO, OP_JALR};
                    end else begin // MV
                        o_instr = {7'b0000000, rs2, REG_ZERO, 3'b000, rd, OP_OP};
                    end
                end else if (rd_zero && rs2_zero) begin
                    o_instr = EBREAK_WORD;
                end else if (rs2_zero) begin // JALR links to ra
                    o_instr = {12'b0, rd, 3'b000, REG_RA, OP_JALR};
                end else begin // ADD
                    o_instr = {7'b0000000, rs2, rd, 3'b000, rd, OP_OP};
                end
            end
            C_SWSP: begin
                o_instr = {
                    swsp_imm[11:5],
                    rs2,
                    REG_SP,
                    3'b010,
                    swsp_imm[4:0],
                    OP_STORE
                };
            end
            default: begin
                o_illegal = 1'b1; // FP and RV64 SP forms
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/rvc_expand_q1.sv
`default_nettype none

module rvc_expand_q1 (
    input  logic [rvc_pkg::CINSTR_W-1:0] i_cinstr,
    output logic [rvc_pkg::INSTR_W-1:0]  o_instr,
    output logic                         o_illegal
);

    import rvc_pkg::*;

    c_funct3_q1_e funct3;
    logic [4:0]   rd;
    logic [4:0]   rd_p;
    logic [4:0]   rs2_p;
    logic [11:0]  imm6_sext;
    logic [11:0]  addi16sp_imm;
    logic [19:0]  lui_imm;
    logic [19:0]  jal_imm;
    logic [6:0]   br_imm_hi;
    logic [4:0]   br_imm_lo;
    logic         imm6_zero;

    assign funct3 = c_funct3_q1_e'(i_cinstr[15:13]);
    assign rd     = i_cinstr[11:7];
    assign rd_p   = {REG_PRIME_BASE, i_cinstr[9:7]};
    assign rs2_p  = {REG_PRIME_BASE, i_cinstr[4:2]};

    assign imm6_sext = {{7{i_cinstr[12]}}, i_cinstr[6:2]};
    assign imm6_zero = ({i_cinstr[12], i_cinstr[6:2]} == 6'b0);

    // nzimm[9|4|6|8:7|5] scaled by 16
    assign addi16sp_imm = {
        {3{i_cinstr[12]}},
        i_cinstr[4:3],
        i_cinstr[5],
        i_cinstr[2],
        i_cinstr[6],
        4'b0000
    };

    assign lui_imm = {{15{i_cinstr[12]}}, i_cinstr[6:2]};

    // JAL layout imm[20|10:1|11|19:12]
    assign jal_imm = {
        i_cinstr[12],
        i_cinstr[8],
        i_cinstr[10:9],
        i_cinstr[6],
        i_cinstr[7],
        i_cinstr[2],
        i_cinstr[11],
        i_cinstr[5:3],
        i_cinstr[12],
        {8{i_cinstr[12]}}
    };

    // Branch layout imm[12|10:5] and imm[4:1|11]
    assign br_imm_hi = {{4{i_cinstr[12]}}, i_cinstr[6:5], i_cinstr[2]};
    assign br_imm_lo = {i_cinstr[11:10], i_cinstr[4:3], i_cinstr[12]};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (funct3)
            C_ADDI: begin
                o_instr = {imm6_sext, rd, 3'b000, rd, OP_OP_IMM};
            end
            C_LI: begin
                o_instr = {imm6_sext, REG_ZERO, 3'b000, rd, OP_OP_IMM};
            end
            C_LUI_ADDI16SP: begin
                if (rd == REG_SP) begin
                    o_instr = {addi16sp_imm, REG_SP, 3'b000, REG_SP, OP_OP_IMM};
                end else begin
                    o_instr = {lui_imm, rd, OP_LUI};
                end
                o_illegal = imm6_zero || (rd == REG_ZERO);
            end
            C_ARITH: begin
                case (i_cinstr[11:10])
                    2'b00: begin // SRLI
                        o_instr   = {7'b0000000, i_cinstr[6:2], rd_p, 3'b101, rd_p, OP_OP_IMM};
                        o_illegal = i_cinstr[12]; // shamt[5] set is RV64 only
                    end
                    2'b01: begin // SRAI
                        o_instr   = {7'b0100000, i_cinstr[6:2], rd_p, 3'b101, rd_p, OP_OP_IMM};
                        o_illegal = i_cinstr[12];
                    end
                    2'b10: begin // ANDI
                        o_instr = {imm6_sext, rd_p, 3'b111, rd_p, OP_OP_IMM};
                    end
                    default: begin
                        o_illegal = i_cinstr[12]; // SUBW and ADDW
                        case (i_cinstr[6:5])
                            2'b00: o_instr = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p, OP_OP};
                            2'b01: o_instr = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p, OP_OP};
                            2'b10: o_instr = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p, OP_OP};
                            default: o_instr = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p, OP_OP};
                        endcase
                    end
                endcase
            end
            C_J: begin
                o_instr = {jal_imm, REG_ZERO, OP_JAL};
            end
            C_BEQZ: begin
                o_instr = {br_imm_hi, REG_ZERO, rd_p, 3'b000, br_imm_lo, OP_BRANCH};
            end
            C_BNEZ: begin
                o_instr = {br_imm_hi, REG_ZERO, rd_p, 3'b001, br_imm_lo, OP_BRANCH};
            end
            default: begin
                o_illegal = 1'b1; // C.JAL and C.ADDIW slot
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/rvc_expand_q0.sv
`default_nettype none

module rvc_expand_q0 (
    input  logic [rvc_pkg::CINSTR_W-1:0] i_cinstr,
    output logic [rvc_pkg::INSTR_W-1:0]  o_instr,
    output logic                         o_illegal
);

    import rvc_pkg::*;

    c_funct3_q0_e funct3;
    logic [4:0]   rd_p;
    logic [4:0]   rs1_p;
    logic [11:0]  addi4spn_imm;
    logic [11:0]  lw_sw_imm;

    assign funct3 = c_funct3_q0_e'(i_cinstr[15:13]);
    assign rd_p   = {REG_PRIME_BASE, i_cinstr[4:2]}; // Also rs2' for C.SW
    assign rs1_p  = {REG_PRIME_BASE, i_cinstr[9:7]};

    // nzuimm[9:2] scaled by 4
    assign addi4spn_imm = {2'b00, i_cinstr[10:7], i_cinstr[12:11],
                           i_cinstr[5], i_cinstr[6], 2'b00};
    // uimm[6:2] scaled by 4
    assign lw_sw_imm    = {5'b0, i_cinstr[5], i_cinstr[12:10], i_cinstr[6], 2'b00};

    always_comb begin
        o_instr   = '0;
        o_illegal = 1'b0;
        case (funct3)
            C_ADDI4SPN: begin
                o_instr = {addi4spn_imm, REG_SP, 3'b000, rd_p, OP_OP_IMM};
                if (i_cinstr[12:5] == 8'b0) begin
                    o_illegal = 1'b1; // Zero immediate is reserved
                end
            end
            C_LW: begin
                o_instr = {lw_sw_imm, rs1_p, 3'b010, rd_p, OP_LOAD};
            end
            C_SW: begin
                o_instr = {
                    lw_sw_imm[11:5],
                    rd_p,
                    rs1_p,
                    3'b010,
                    lw_sw_imm[4:0],
                    OP_STORE
                };
            end
            default: begin
                o_illegal = 1'b1; // FP and RV64 forms
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    localparam int unsigned INSTR_W  = 32;
    localparam int unsigned CINSTR_W = 16;

    // Low two bits of the fetch word
    typedef enum logic [1:0] {
        Q0      = 2'b00,
        Q1      = 2'b01,
        Q2      = 2'b10,
        Q3_FULL = 2'b11 // Not compressed
    } quadrant_e;

    // Base major opcodes
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_OP_IMM = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        C_ADDI4SPN = 3'b000,
        C_LW       = 3'b010,
        C_SW       = 3'b110
    } c_funct3_q0_e;

    typedef enum logic [2:0] {
        C_ADDI         = 3'b000, // Also C.NOP
        C_LI           = 3'b010,
        C_LUI_ADDI16SP = 3'b011,
        C_ARITH        = 3'b100,
        C_J            = 3'b101,
        C_BEQZ         = 3'b110,
        C_BNEZ         = 3'b111
    } c_funct3_q1_e;

    typedef enum logic [2:0] {
        C_SLLI      = 3'b000,
        C_LWSP      = 3'b010,
        C_JR_MV_ADD = 3'b100, // Also EBREAK and JALR
        C_SWSP      = 3'b110
    } c_funct3_q2_e;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    // Compressed 3-bit register fields map to x8..x15
    localparam logic [1:0] REG_PRIME_BASE = 2'b01;

    localparam logic [INSTR_W-1:0] EBREAK_WORD = {
        12'h001,
        REG_ZERO,
        3'b000,
        REG_ZERO,
        OP_SYSTEM
    };

endpackage

`default_nettype wire
